// ==== regex_pkg.sv ====
package regex_pkg;

  localparam int LANES      = 4;    // one lane per char plus end-of-string
  localparam int FIFO_DEPTH = 16;   // threads per lane
  localparam int PROG_DEPTH = 256;  // program words

  typedef logic [7:0] pc_t;
  typedef logic [7:0] char_t;
  typedef logic [1:0] lane_t;  // also the string length

  // opcodes
  localparam logic [1:0] OP_MATCH  = 2'd0;  // consume operand char
  localparam logic [1:0] OP_JMP    = 2'd1;  // goto operand
  localparam logic [1:0] OP_SPLIT  = 2'd2;  // fork to pc+1 and operand
  localparam logic [1:0] OP_ACCEPT = 2'd3;

  // 16-bit program word
  typedef struct packed {
    logic [5:0] unused;
    logic [1:0] op;
    pc_t        operand;
  } instr_t;

  // one job, char 0 in the low bits
  typedef struct packed {
    lane_t                  len;
    char_t [LANES-1:0]      chars;
  } job_t;

endpackage

// ==== pc_arbiter.sv ====
`timescale 1ns/1ns

module pc_arbiter import regex_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic in0_valid,
  input  pc_t  in0_pc,
  output logic in0_ready,
  input  logic in1_valid,
  input  pc_t  in1_pc,
  output logic in1_ready,
  output logic out_valid,
  output pc_t  out_pc,
  input  logic out_ready
);

  logic last_grant;  // 1 when in1 won last
  logic grant1;

  // round robin only matters when both request
  always_comb begin
    if (in0_valid && in1_valid) begin
      grant1 = ~last_grant;
    end else begin
      grant1 = in1_valid;
    end
  end

  assign out_valid = in0_valid | in1_valid;
  assign out_pc    = grant1 ? in1_pc : in0_pc;
  assign in0_ready = out_ready & ~grant1;
  assign in1_ready = out_ready & grant1;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= 1'b0;
    end else if (out_valid && out_ready) begin
      last_grant <= grant1;  // remember winner of this transfer
    end
  end

endmodule

// ==== pc_fifo.sv ====
`timescale 1ns/1ns

module pc_fifo import regex_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic wr_valid,
  input  pc_t  wr_pc,
  output logic wr_ready,
  output logic rd_valid,
  output pc_t  rd_pc,
  input  logic rd_ready,
  output logic empty
);

  pc_t                             mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH):0]     count;
  logic                            full;
  logic                            push;
  logic                            pop;

  assign wr_ready = ~full;
  assign rd_valid = ~empty;
  assign rd_pc    = mem[rd_ptr];
  assign push     = wr_valid & wr_ready;
  assign pop      = rd_valid & rd_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_pc;
    end
  end

  // flags registered alongside the count
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
          full  <= (count == FIFO_DEPTH - 1);
          empty <= 1'b0;
        end
        2'b01: begin
          count <= count - 1'b1;
          full  <= 1'b0;
          empty <= (count == 1);
        end
        default: ;  // idle or push+pop, level unchanged
      endcase
    end
  end

endmodule

// ==== regex_cpu.sv ====
`timescale 1ns/1ns

module regex_cpu import regex_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  input  pc_t    in_pc,
  output logic   in_ready,
  input  char_t  lane_char,
  input  logic   lane_at_end,
  input  logic   lane_enable,
  output pc_t    fetch_addr,
  input  instr_t fetch_instr,
  output logic   same_valid,
  output pc_t    same_pc,
  input  logic   same_ready,
  output logic   fwd_valid,
  output pc_t    fwd_pc,
  input  logic   fwd_ready,
  output logic   accept_hit,
  output logic   busy
);

  typedef enum logic [2:0] {
    st_idle,
    st_exec,
    st_emit_same,
    st_emit_second,  // pc+1 of a split, operand still pending
    st_emit_fwd
  } state_t;

  state_t state;
  pc_t    pc_r;    // thread being run
  pc_t    out_pc;  // result on offer
  pc_t    alt_pc;  // second branch of a split

  assign in_ready   = (state == st_idle) && lane_enable;
  assign busy       = (state != st_idle);
  assign fetch_addr = pc_r;  // read port is combinational

  assign same_valid = (state == st_emit_same) || (state == st_emit_second);
  assign same_pc    = out_pc;
  assign fwd_valid  = (state == st_emit_fwd);
  assign fwd_pc     = out_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      accept_hit <= 1'b0;
    end else begin
      accept_hit <= 1'b0;
      case (state)
        st_idle: begin
          if (in_valid && in_ready) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          case (fetch_instr.op)
            OP_MATCH: begin
              // anything that fails the char test just dies
              if (!lane_at_end && lane_char == fetch_instr.operand) begin
                state <= st_emit_fwd;
              end else begin
                state <= st_idle;
              end
            end
            OP_JMP:   state <= st_emit_same;
            OP_SPLIT: state <= st_emit_second;
            default: begin
              accept_hit <= lane_at_end;  // accept only at end of string
              state      <= st_idle;
            end
          endcase
        end
        st_emit_second: begin
          if (same_ready) state <= st_emit_same;
        end
        st_emit_same: begin
          if (same_ready) state <= st_idle;
        end
        st_emit_fwd: begin
          if (fwd_ready) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // thread and result registers
  always_ff @(posedge clk) begin
    if (state == st_idle && in_valid && in_ready) begin
      pc_r <= in_pc;
    end
    if (state == st_exec) begin
      alt_pc <= fetch_instr.operand;
      if (fetch_instr.op == OP_JMP) begin
        out_pc <= fetch_instr.operand;
      end else begin
        out_pc <= pc_r + 8'd1;  // match and split both go to pc+1
      end
    end
    if (state == st_emit_second && same_ready) begin
      out_pc <= alt_pc;
    end
  end

endmodule

// ==== program_memory.sv ====
`timescale 1ns/1ns

module program_memory import regex_pkg::*; (
  input  logic                 clk,
  input  logic                 prog_we,
  input  pc_t                  prog_addr,
  input  instr_t               prog_data,
  input  pc_t    [LANES-1:0]   rd_addr,
  output instr_t [LANES-1:0]   rd_instr
);

  instr_t mem [PROG_DEPTH];

  // single load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // one async read per lane cpu
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rd_instr[i] = mem[rd_addr[i]];
    end
  end

endmodule

// ==== engine_control.sv ====
`timescale 1ns/1ns

module engine_control import regex_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  input  job_t                job,
  output logic                ack,
  output logic                matched,
  output logic                start_valid,
  output pc_t                 start_pc,
  input  logic                start_ready,
  output char_t [LANES-1:0]   lane_char,
  output logic  [LANES-1:0]   lane_at_end,
  output logic  [LANES-1:0]   lane_enable,
  input  logic  [LANES-1:0]   cpu_busy,
  input  logic  [LANES-1:0]   cpu_accept,
  input  logic  [LANES-1:0]   fifo_empty
);

  typedef enum logic [2:0] {
    st_idle,
    st_inject,
    st_run,
    st_done,
    st_release
  } state_t;

  state_t     state;
  job_t       job_r;
  logic       req_q;     // for edge detect
  logic       idle_cnt;  // one quiet cycle already seen
  logic       all_idle;

  assign all_idle    = (&fifo_empty) && !(|cpu_busy);
  assign ack         = (state == st_done);
  assign start_valid = (state == st_inject);
  assign start_pc    = '0;  // programs start at 0

  // per-lane view of the latched string
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_char[i]   = job_r.chars[i];
      lane_at_end[i] = (lane_t'(i) == job_r.len);
      lane_enable[i] = (lane_t'(i) <= job_r.len);
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && req && !req_q) begin
      job_r <= job;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      req_q    <= 1'b0;
      matched  <= 1'b0;
      idle_cnt <= '0;
    end else begin
      req_q <= req;
      case (state)
        st_idle: begin
          if (req && !req_q) begin
            matched <= 1'b0;
            state   <= st_inject;
          end
        end
        st_inject: begin
          idle_cnt <= '0;
          if (start_ready) state <= st_run;
        end
        st_run: begin
          if (|cpu_accept) matched <= 1'b1;  // sticky until next job
          if (!all_idle) begin
            idle_cnt <= '0;
          end else if (idle_cnt == 1'b1) begin
            state <= st_done;  // second quiet cycle in a row
          end else begin
            idle_cnt <= 1'b1;
          end
        end
        st_done: begin
          if (!req) state <= st_release;
        end
        st_release: state <= st_idle;  // ack already low here
        default:    state <= st_idle;
      endcase
    end
  end

endmodule

// ==== vectorial_engine.sv ====
`timescale 1ns/1ns

module vectorial_engine import regex_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   req,
  input  job_t   job,
  output logic   ack,
  output logic   matched,
  input  logic   prog_we,
  input  pc_t    prog_addr,
  input  instr_t prog_data
);

  // link[0] is the start thread, link[i+1] the forward output of cpu i
  logic   [LANES:0]     link_valid;
  pc_t    [LANES:0]     link_pc;
  logic   [LANES:0]     link_ready;

  logic   [LANES-1:0]   same_valid;
  pc_t    [LANES-1:0]   same_pc;
  logic   [LANES-1:0]   same_ready;
  logic   [LANES-1:0]   arb_valid;
  pc_t    [LANES-1:0]   arb_pc;
  logic   [LANES-1:0]   arb_ready;   // fifo not full
  logic   [LANES-1:0]   fifo_valid;
  pc_t    [LANES-1:0]   fifo_pc;
  logic   [LANES-1:0]   fifo_ready;
  logic   [LANES-1:0]   fifo_empty;
  char_t  [LANES-1:0]   lane_char;
  logic   [LANES-1:0]   lane_at_end;
  logic   [LANES-1:0]   lane_enable;
  logic   [LANES-1:0]   cpu_busy;
  logic   [LANES-1:0]   cpu_accept;
  pc_t    [LANES-1:0]   fetch_addr;
  instr_t [LANES-1:0]   fetch_instr;

  assign link_ready[LANES] = 1'b1;  // a match on the last lane always dies

  engine_control engine_control_i (
    .clk(clk), .reset(reset),
    .req(req), .job(job), .ack(ack), .matched(matched),
    .start_valid(link_valid[0]), .start_pc(link_pc[0]), .start_ready(link_ready[0]),
    .lane_char(lane_char), .lane_at_end(lane_at_end), .lane_enable(lane_enable),
    .cpu_busy(cpu_busy), .cpu_accept(cpu_accept), .fifo_empty(fifo_empty)
  );

  program_memory program_memory_i (
    .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .rd_addr(fetch_addr), .rd_instr(fetch_instr)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    pc_arbiter pc_arbiter_i (
      .clk(clk), .reset(reset),
      .in0_valid(link_valid[i]), .in0_pc(link_pc[i]), .in0_ready(link_ready[i]),
      .in1_valid(same_valid[i]), .in1_pc(same_pc[i]), .in1_ready(same_ready[i]),
      .out_valid(arb_valid[i]), .out_pc(arb_pc[i]), .out_ready(arb_ready[i])
    );

    pc_fifo pc_fifo_i (
      .clk(clk), .reset(reset),
      .wr_valid(arb_valid[i]), .wr_pc(arb_pc[i]), .wr_ready(arb_ready[i]),
      .rd_valid(fifo_valid[i]), .rd_pc(fifo_pc[i]), .rd_ready(fifo_ready[i]),
      .empty(fifo_empty[i])
    );

    regex_cpu regex_cpu_i (
      .clk(clk), .reset(reset),
      .in_valid(fifo_valid[i]), .in_pc(fifo_pc[i]), .in_ready(fifo_ready[i]),
      .lane_char(lane_char[i]), .lane_at_end(lane_at_end[i]),
      .lane_enable(lane_enable[i]),
      .fetch_addr(fetch_addr[i]), .fetch_instr(fetch_instr[i]),
      .same_valid(same_valid[i]), .same_pc(same_pc[i]), .same_ready(same_ready[i]),
      .fwd_valid(link_valid[i+1]), .fwd_pc(link_pc[i+1]), .fwd_ready(link_ready[i+1]),
      .accept_hit(cpu_accept[i]), .busy(cpu_busy[i])
    );
  end

endmodule

// ==== vectorial_engine_tb.sv ====
`timescale 1ns/1ns

module vectorial_engine_tb import regex_pkg::*; ();

  localparam int TIMEOUT = 2000;  // cycles allowed per wait

  logic   clk = 1'b0;
  logic   reset;
  logic   req;
  job_t   job;
  logic   ack;
  logic   matched;
  logic   prog_we;
  pc_t    prog_addr;
  instr_t prog_data;

  instr_t ref_prog [PROG_DEPTH];  // copy of the loaded program
  job_t   ref_job;
  string  cur_text;               // string of the job in flight
  bit     expected;
  bit     ack_q;
  bit     timed_out;
  int     seed = 87;
  int     errors;
  int     checks;
  int     jobs;
  int     tests;
  int     test_errors;
  int     test_jobs;

  vectorial_engine vectorial_engine_i (
    .clk(clk), .reset(reset), .req(req), .job(job), .ack(ack), .matched(matched),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
  );

  always #50 clk = ~clk;

  // backtracking matcher, anchored at both ends
  function automatic bit ref_match(input int pc, input int pos);
    instr_t ins;
    ins = ref_prog[pc % PROG_DEPTH];
    case (ins.op)
      OP_MATCH: begin
        if (pos < ref_job.len && ref_job.chars[pos] == ins.operand) begin
          return ref_match(pc + 1, pos + 1);
        end
        return 1'b0;
      end
      OP_JMP:   return ref_match(ins.operand, pos);
      OP_SPLIT: return ref_match(pc + 1, pos) || ref_match(ins.operand, pos);
      default:  return (pos == ref_job.len);  // accept
    endcase
  endfunction

  task automatic put_word(input pc_t addr, input logic [1:0] op, input pc_t operand);
    instr_t w;
    w = instr_t'({6'd0, op, operand});
    ref_prog[addr] = w;
    @(posedge clk);
    prog_we   <= 1'b1;
    prog_addr <= addr;
    prog_data <= w;
  endtask

  task automatic load_program(input int which);
    case (which)
      0: begin  // ab
        put_word(0, OP_MATCH, "a");
        put_word(1, OP_MATCH, "b");
        put_word(2, OP_ACCEPT, 0);
      end
      1, 2: begin  // a|b, or a*b when the jump goes back to 0
        put_word(0, OP_SPLIT, 3);
        put_word(1, OP_MATCH, "a");
        put_word(2, OP_JMP, (which == 1) ? 8'd4 : 8'd0);
        put_word(3, OP_MATCH, "b");
        put_word(4, OP_ACCEPT, 0);
      end
      3: put_word(0, OP_ACCEPT, 0);
      default: begin  // single a
        put_word(0, OP_MATCH, "a");
        put_word(1, OP_ACCEPT, 0);
      end
    endcase
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  // one four-phase job, expected value goes to the checker
  task automatic run_job(input string s);
    job_t j;
    int   cnt;
    if (timed_out) return;
    j = '0;
    j.len = lane_t'(s.len());
    for (int i = 0; i < s.len(); i++) begin
      j.chars[i] = s[i];
    end
    ref_job  = j;
    cur_text = s;
    expected = ref_match(0, 0);
    @(posedge clk);
    job <= j;
    req <= 1'b1;
    cnt = 0;
    @(negedge clk);
    while (ack !== 1'b1 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack !== 1'b1) begin
      $display("timeout at %0t: no ack for string \"%s\"", $time, s);
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);
    req <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (ack !== 1'b0 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack !== 1'b0) begin
      $display("timeout at %0t: ack stayed high after req fell", $time);
      timed_out = 1'b1;
      return;
    end
    jobs++;
    test_jobs++;
  endtask

  function automatic string random_text();
    string s;
    int    len;
    s   = "";
    len = $unsigned($random(seed)) % 4;
    for (int k = 0; k < len; k++) begin
      if ($random(seed) & 1) begin
        s = {s, "b"};
      end else begin
        s = {s, "a"};
      end
    end
    return s;
  endfunction

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errors && !timed_out) begin
      $display("test %0d %s: ok, %0d jobs", tests, name, test_jobs);
    end else begin
      $display("test %0d %s: failed, %0d jobs", tests, name, test_jobs);
    end
    test_errors = errors;
    test_jobs   = 0;
  endtask

  // outputs sampled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (ack && !ack_q) begin
        checks++;
        if (!req) begin
          $display("ack rose at %0t while req was low", $time);
          errors++;
        end
        if (matched !== expected) begin
          $display("MISMATCH at %0t: string \"%s\" gave matched=%b, expected %b",
                   $time, cur_text, matched, expected);
          errors++;
        end
      end
      if (!ack && ack_q && req) begin
        $display("ack fell at %0t before req was lowered", $time);
        errors++;
      end
      ack_q = ack;
    end
  end

  initial begin
    string alpha;
    alpha     = "abc";
    reset     = 1'b1;
    req       = 1'b0;
    job       = '0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    load_program(0);
    run_job("ab");
    run_job("a");
    run_job("ba");
    run_job("abc");
    end_test("literal ab");

    load_program(1);
    for (int i = 0; i < 3; i++) begin
      run_job(alpha.substr(i, i));
      for (int k = 0; k < 3; k++) begin
        run_job({alpha.substr(i, i), alpha.substr(k, k)});
      end
    end
    end_test("alternation a|b");

    load_program(2);
    for (int n = 0; n < 40; n++) begin
      run_job(random_text());
    end
    end_test("star a*b");

    load_program(3);
    run_job("");
    load_program(4);
    run_job("");
    run_job("a");
    end_test("empty string");

    // ack must stay quiet with req low
    repeat (10) begin
      @(negedge clk);
      if (ack !== 1'b0) begin
        $display("ack high at %0t with no request", $time);
        errors++;
      end
    end
    load_program(2);
    for (int n = 0; n < 10; n++) begin
      run_job(random_text());
    end
    end_test("handshake back to back");

    if (!timed_out && checks != jobs) begin
      $display("%0d acks seen for %0d completed jobs", checks, jobs);
      errors++;
    end
    $display("%0d tests, %0d jobs, %0d checks, %0d errors", tests, jobs, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vectorial_engine.f ====
regex_pkg.sv
pc_arbiter.sv
pc_fifo.sv
regex_cpu.sv
program_memory.sv
engine_control.sv
vectorial_engine.sv
vectorial_engine_tb.sv
